//--- hdl/mvm_pkg.sv
package mvm_pkg;

    //////////////////////////////////////////////////
    // index width and sequencer state
    //////////////////////////////////////////////////

    // 8 bit row and column indices, so both dimensions stay at or below 255
    localparam int IDX_WIDTH = 8;

    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0, // waiting for both operands
        SEQ_CALC = 2'd1, // tiles in flight
        SEQ_DONE = 2'd2  // result held until accepted
    } seq_state_t;

    //////////////////////////////////////////////////
    // tile position
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [IDX_WIDTH-1:0] row_base; // first matrix row of the tile
        logic [IDX_WIDTH-1:0] col_base; // first matrix column of the tile
        logic                 first;    // first tile of the run
        logic                 last;     // last tile of the run
    } tile_pos_t;

    //////////////////////////////////////////////////
    // tile arithmetic
    //////////////////////////////////////////////////

    function automatic int unsigned ceil_div(
        input int unsigned num,
        input int unsigned den
    );
        return (num + den - 1) / den;
    endfunction

    // tiles per run, rows times column groups
    function automatic int unsigned tile_count(
        input int unsigned height,
        input int unsigned width,
        input int unsigned tiling_row,
        input int unsigned tiling_col
    );
        int unsigned row_groups;
        int unsigned col_groups;
        row_groups = ceil_div(height, tiling_row);
        col_groups = ceil_div(width, tiling_col);
        return row_groups * col_groups;
    endfunction

endpackage

//--- hdl/operand_buffer.sv
module operand_buffer #(
    parameter int MATRIX_WIDTH      = 4,
    parameter int MATRIX_HEIGHT     = 5,
    parameter int VECTOR_CELL_WIDTH = 8,
    parameter int MATRIX_CELL_WIDTH = 8
)(
    input  logic                                                  clk,
    input  logic                                                  rst,
    // vector port
    input  logic [MATRIX_HEIGHT*VECTOR_CELL_WIDTH-1:0]              vector,
    input  logic                                                  vector_valid,
    output logic                                                  vector_ready,
    // matrix port
    input  logic [MATRIX_WIDTH*MATRIX_HEIGHT*MATRIX_CELL_WIDTH-1:0] matrix,
    input  logic                                                  matrix_valid,
    output logic                                                  matrix_ready,
    // from the sequencer, once the result is taken
    input  logic                                                  buf_release,
    // held operands
    output logic [MATRIX_HEIGHT*VECTOR_CELL_WIDTH-1:0]              vector_held,
    output logic [MATRIX_WIDTH*MATRIX_HEIGHT*MATRIX_CELL_WIDTH-1:0] matrix_held,
    output logic                                                  both_held
);

    logic vector_set; // vector captured, waiting for release
    logic matrix_set; // matrix captured, waiting for release

    //////////////////////////////////////////////////
    // vector capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || buf_release) begin
            vector_set  <= 1'b0;
            vector_held <= '0;
        end else if (vector_valid && vector_ready) begin
            vector_set  <= 1'b1;
            vector_held <= vector;
        end
    end

    //////////////////////////////////////////////////
    // matrix capture
    //////////////////////////////////////////////////

    // independent of the vector, so the two may come in any order
    always_ff @(posedge clk) begin
        if (rst || buf_release) begin
            matrix_set  <= 1'b0;
            matrix_held <= '0;
        end else if (matrix_valid && matrix_ready) begin
            matrix_set  <= 1'b1;
            matrix_held <= matrix;
        end
    end

    assign vector_ready = !vector_set;
    assign matrix_ready = !matrix_set;
    assign both_held    = vector_set && matrix_set; // sequencer may start

endmodule

//--- hdl/tile_sequencer.sv
module tile_sequencer import mvm_pkg::*; #(
    parameter int MATRIX_WIDTH  = 4,
    parameter int MATRIX_HEIGHT = 5,
    parameter int TILING_ROW    = 3,
    parameter int TILING_COL    = 3
)(
    input  logic       clk,
    input  logic       rst,
    input  logic       both_held,
    input  logic       result_ready,
    output seq_state_t state,
    output tile_pos_t  tile,
    output logic       tile_strobe,
    output logic       buf_release
);

    localparam int TILES     = tile_count(MATRIX_HEIGHT, MATRIX_WIDTH, TILING_ROW, TILING_COL);
    localparam int CNT_WIDTH = $clog2(TILES + 1);

    logic [CNT_WIDTH-1:0] remaining; // tiles still to issue after the current one
    tile_pos_t            next_tile;

    //////////////////////////////////////////////////
    // tile walk
    //////////////////////////////////////////////////

    // all row bases of a column group, then the next column group
    always_comb begin
        next_tile       = tile;
        next_tile.first = 1'b0;
        next_tile.last  = (remaining == CNT_WIDTH'(1));
        if (int'(tile.row_base) + TILING_ROW < MATRIX_HEIGHT) begin
            next_tile.row_base = tile.row_base + IDX_WIDTH'(TILING_ROW);
        end else begin
            next_tile.row_base = '0;
            next_tile.col_base = tile.col_base + IDX_WIDTH'(TILING_COL);
        end
    end

    //////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= SEQ_IDLE;
            tile_strobe <= 1'b0;
            remaining   <= '0;
            tile        <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (both_held) begin
                        state          <= SEQ_CALC;
                        tile_strobe    <= 1'b1; // first tile goes out with CALC
                        remaining      <= CNT_WIDTH'(TILES - 1);
                        tile.row_base  <= '0;
                        tile.col_base  <= '0;
                        tile.first     <= 1'b1;
                        tile.last      <= (TILES == 1);
                    end
                end
                SEQ_CALC: begin
                    if (!tile_strobe) begin
                        state <= SEQ_DONE; // last products added in the drain cycle
                    end else if (tile.last) begin
                        tile_strobe <= 1'b0;
                    end else begin
                        tile      <= next_tile;
                        remaining <= remaining - 1'b1;
                    end
                end
                SEQ_DONE: begin
                    if (result_ready) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // buffer clears on the acceptance edge
    assign buf_release = (state == SEQ_DONE) && result_ready;

endmodule

//--- hdl/vector_mac.sv
module vector_mac import mvm_pkg::*; #(
    parameter int MATRIX_WIDTH      = 4,
    parameter int MATRIX_HEIGHT     = 5,
    parameter int VECTOR_CELL_WIDTH = 8,
    parameter int MATRIX_CELL_WIDTH = 8,
    parameter int TILING_COL        = 3,
    parameter int ROW_OFFSET        = 0  // row of this unit inside the tile
)(
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [MATRIX_HEIGHT*VECTOR_CELL_WIDTH-1:0]              vector_held,
    input  logic [MATRIX_WIDTH*MATRIX_HEIGHT*MATRIX_CELL_WIDTH-1:0] matrix_held,
    input  tile_pos_t                                             tile,
    input  logic                                                  tile_strobe,
    output logic [TILING_COL*(VECTOR_CELL_WIDTH+MATRIX_CELL_WIDTH)-1:0] products,
    output logic                                                  products_valid,
    output tile_pos_t                                             products_tile
);

    localparam int PRODUCT_WIDTH = VECTOR_CELL_WIDTH + MATRIX_CELL_WIDTH;

    logic [IDX_WIDTH:0]           row;                       // one extra bit, base plus offset
    logic [IDX_WIDTH:0]           col          [TILING_COL];
    logic [VECTOR_CELL_WIDTH-1:0] vector_cell;
    logic [MATRIX_CELL_WIDTH-1:0] matrix_cells [TILING_COL];

    //////////////////////////////////////////////////
    // operand select
    //////////////////////////////////////////////////

    always_comb begin
        row         = tile.row_base + (IDX_WIDTH+1)'(ROW_OFFSET);
        vector_cell = '0; // rows past the bottom edge add nothing
        if (row < MATRIX_HEIGHT) begin
            vector_cell = vector_held[row*VECTOR_CELL_WIDTH +: VECTOR_CELL_WIDTH];
        end
        for (int c = 0; c < TILING_COL; c++) begin
            col[c]          = tile.col_base + (IDX_WIDTH+1)'(c);
            matrix_cells[c] = '0;
            if (row < MATRIX_HEIGHT && col[c] < MATRIX_WIDTH) begin
                matrix_cells[c] =
                    matrix_held[(row*MATRIX_WIDTH + col[c])*MATRIX_CELL_WIDTH +: MATRIX_CELL_WIDTH];
            end
        end
    end

    //////////////////////////////////////////////////
    // multiply stage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            products_valid <= 1'b0;
        end else begin
            products_valid <= tile_strobe;
        end
    end

    // full width products, no truncation here
    always_ff @(posedge clk) begin
        for (int c = 0; c < TILING_COL; c++) begin
            products[c*PRODUCT_WIDTH +: PRODUCT_WIDTH] <= vector_cell * matrix_cells[c];
        end
        products_tile <= tile; // position travels with its products
    end

endmodule

//--- hdl/result_accumulator.sv
module result_accumulator import mvm_pkg::*; #(
    parameter int MATRIX_WIDTH      = 4,
    parameter int RESULT_CELL_WIDTH = 8,
    parameter int FRACTION_WIDTH    = 4,
    parameter int TILING_ROW        = 3,
    parameter int TILING_COL        = 3,
    parameter int PRODUCT_WIDTH     = 16
)(
    input  logic                                          clk,
    input  logic                                          rst,
    input  seq_state_t                                    state,
    input  logic [TILING_ROW*TILING_COL*PRODUCT_WIDTH-1:0] products,
    input  logic                                          products_valid,
    input  tile_pos_t                                     products_tile,
    output logic [MATRIX_WIDTH*RESULT_CELL_WIDTH-1:0]     result,
    output logic                                          result_valid,
    output logic                                          error
);

    // room for up to 255 rows of full width products
    localparam int SUM_WIDTH = PRODUCT_WIDTH + IDX_WIDTH;

    logic [SUM_WIDTH-1:0]    sums      [MATRIX_WIDTH];
    logic [SUM_WIDTH-1:0]    next_sums [MATRIX_WIDTH];
    logic [SUM_WIDTH-1:0]    tile_sums [TILING_COL];
    logic [SUM_WIDTH-1:0]    shifted   [MATRIX_WIDTH];
    logic [MATRIX_WIDTH-1:0] overflow;

    //////////////////////////////////////////////////
    // column sums
    //////////////////////////////////////////////////

    // add up the rows of each tile column
    always_comb begin
        for (int c = 0; c < TILING_COL; c++) begin
            tile_sums[c] = '0;
            for (int r = 0; r < TILING_ROW; r++) begin
                tile_sums[c] = tile_sums[c] +
                    products[(r*TILING_COL + c)*PRODUCT_WIDTH +: PRODUCT_WIDTH];
            end
        end
    end

    // route tile columns onto matrix columns, columns past the edge fall away
    always_comb begin
        for (int k = 0; k < MATRIX_WIDTH; k++) begin
            next_sums[k] = products_tile.first ? '0 : sums[k];
            for (int c = 0; c < TILING_COL; c++) begin
                if (int'(products_tile.col_base) + c == k) begin
                    next_sums[k] = next_sums[k] + tile_sums[c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sums <= '{default: '0};
        end else if (products_valid) begin
            sums <= next_sums;
        end
    end

    //////////////////////////////////////////////////
    // scale and range check
    //////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < MATRIX_WIDTH; k++) begin
            shifted[k] = sums[k] >> FRACTION_WIDTH; // drop the fraction, no rounding
            result[k*RESULT_CELL_WIDTH +: RESULT_CELL_WIDTH] = shifted[k][RESULT_CELL_WIDTH-1:0];
            overflow[k] = (shifted[k] >> RESULT_CELL_WIDTH) != '0;
        end
    end

    assign result_valid = (state == SEQ_DONE);
    assign error        = result_valid && (|overflow); // any column out of range

endmodule

//--- hdl/mvm.sv
module mvm import mvm_pkg::*; #(
    parameter int MATRIX_WIDTH      = 4, // columns, also the number of result cells
    parameter int MATRIX_HEIGHT     = 5, // rows, also the vector length
    parameter int VECTOR_CELL_WIDTH = 8,
    parameter int MATRIX_CELL_WIDTH = 8,
    parameter int RESULT_CELL_WIDTH = 8,
    parameter int FRACTION_WIDTH    = 4,
    parameter int TILING_ROW        = 3, // vector_mac units
    parameter int TILING_COL        = 3  // multipliers per unit
)(
    input  logic                                                  clk,
    input  logic                                                  rst,
    // vector port
    input  logic [MATRIX_HEIGHT*VECTOR_CELL_WIDTH-1:0]              vector,
    input  logic                                                  vector_valid,
    output logic                                                  vector_ready,
    // matrix port
    input  logic [MATRIX_WIDTH*MATRIX_HEIGHT*MATRIX_CELL_WIDTH-1:0] matrix,
    input  logic                                                  matrix_valid,
    output logic                                                  matrix_ready,
    // result port
    output logic [MATRIX_WIDTH*RESULT_CELL_WIDTH-1:0]               result,
    output logic                                                  result_valid,
    input  logic                                                  result_ready,
    output logic                                                  error // overflow
);

    localparam int PRODUCT_WIDTH = VECTOR_CELL_WIDTH + MATRIX_CELL_WIDTH;
    localparam int GROUP_WIDTH   = TILING_COL * PRODUCT_WIDTH;

    logic [MATRIX_HEIGHT*VECTOR_CELL_WIDTH-1:0]              vector_held;
    logic [MATRIX_WIDTH*MATRIX_HEIGHT*MATRIX_CELL_WIDTH-1:0] matrix_held;
    logic                                                  both_held;
    logic                                                  buf_release;
    seq_state_t                                            state;
    tile_pos_t                                             tile;
    logic                                                  tile_strobe;
    logic [TILING_ROW*GROUP_WIDTH-1:0]                     products;
    logic [TILING_ROW-1:0]                                 row_valid;
    tile_pos_t                                             row_tile [TILING_ROW];

    //////////////////////////////////////////////////
    // operands and control
    //////////////////////////////////////////////////

    operand_buffer #(
        .MATRIX_WIDTH      (MATRIX_WIDTH),
        .MATRIX_HEIGHT     (MATRIX_HEIGHT),
        .VECTOR_CELL_WIDTH (VECTOR_CELL_WIDTH),
        .MATRIX_CELL_WIDTH (MATRIX_CELL_WIDTH)
    ) u_operand_buffer (
        .clk, .rst,
        .vector, .vector_valid, .vector_ready,
        .matrix, .matrix_valid, .matrix_ready,
        .buf_release, .vector_held, .matrix_held, .both_held
    );

    tile_sequencer #(
        .MATRIX_WIDTH  (MATRIX_WIDTH),
        .MATRIX_HEIGHT (MATRIX_HEIGHT),
        .TILING_ROW    (TILING_ROW),
        .TILING_COL    (TILING_COL)
    ) u_tile_sequencer (
        .clk, .rst, .both_held, .result_ready,
        .state, .tile, .tile_strobe, .buf_release
    );

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    for (genvar r = 0; r < TILING_ROW; r++) begin : g_row
        vector_mac #(
            .MATRIX_WIDTH      (MATRIX_WIDTH),
            .MATRIX_HEIGHT     (MATRIX_HEIGHT),
            .VECTOR_CELL_WIDTH (VECTOR_CELL_WIDTH),
            .MATRIX_CELL_WIDTH (MATRIX_CELL_WIDTH),
            .TILING_COL        (TILING_COL),
            .ROW_OFFSET        (r)
        ) u_vector_mac (
            .clk, .rst, .vector_held, .matrix_held, .tile, .tile_strobe,
            .products       (products[r*GROUP_WIDTH +: GROUP_WIDTH]),
            .products_valid (row_valid[r]),
            .products_tile  (row_tile[r])
        );
    end

    result_accumulator #(
        .MATRIX_WIDTH      (MATRIX_WIDTH),
        .RESULT_CELL_WIDTH (RESULT_CELL_WIDTH),
        .FRACTION_WIDTH    (FRACTION_WIDTH),
        .TILING_ROW        (TILING_ROW),
        .TILING_COL        (TILING_COL),
        .PRODUCT_WIDTH     (PRODUCT_WIDTH)
    ) u_result_accumulator (
        .clk, .rst, .state, .products,
        .products_valid (&row_valid), // all rows move in lockstep
        .products_tile  (row_tile[0]),
        .result, .result_valid, .error
    );

endmodule

//--- bench/mvm_tb.sv
module mvm_tb import mvm_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MW       = 4; // matrix width, result cells
    localparam int MH       = 5; // matrix height, vector cells
    localparam int VW       = 8;
    localparam int MCW      = 8;
    localparam int RW       = 8;
    localparam int FW       = 4;
    localparam int TR       = 3;
    localparam int TC       = 3;
    localparam int PERIOD   = 40;
    localparam int TILES    = tile_count(MH, MW, TR, TC);
    localparam int NUM_RUNS = 31; // operand sets sent over all tests
    localparam int WATCHDOG = NUM_RUNS * (TILES + 20) * PERIOD;

    typedef logic [MH*VW-1:0]     vec_t;
    typedef logic [MW*MH*MCW-1:0] mat_t;
    typedef logic [MW*RW-1:0]     res_t;

    logic clk;
    logic rst;
    vec_t vector;
    logic vector_valid;
    logic vector_ready;
    mat_t matrix;
    logic matrix_valid;
    logic matrix_ready;
    res_t result;
    logic result_valid;
    logic result_ready;
    logic error;

    int value_errors    = 0;
    int protocol_errors = 0;

    mvm dut (
        .clk, .rst,
        .vector, .vector_valid, .vector_ready,
        .matrix, .matrix_valid, .matrix_ready,
        .result, .result_valid, .result_ready,
        .error
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // reference model and operand builders
    //////////////////////////////////////////////////

    function automatic void expected_result(input vec_t v, input mat_t m,
                                            output res_t res, output logic err);
        longint unsigned sum;
        longint unsigned shifted;
        res = '0;
        err = 1'b0;
        for (int c = 0; c < MW; c++) begin
            sum = 0;
            for (int r = 0; r < MH; r++) begin
                sum += v[r*VW +: VW] * m[(r*MW + c)*MCW +: MCW];
            end
            shifted = sum >> FW;
            res[c*RW +: RW] = shifted[RW-1:0];
            if (shifted > (64'd1 << RW) - 1) begin
                err = 1'b1; // does not fit in a result cell
            end
        end
    endfunction

    function automatic vec_t random_vector(input logic [VW-1:0] mask);
        vec_t v;
        for (int r = 0; r < MH; r++) begin
            v[r*VW +: VW] = $urandom() & mask;
        end
        return v;
    endfunction

    function automatic mat_t random_matrix(input logic [MCW-1:0] mask);
        mat_t m;
        for (int i = 0; i < MW*MH; i++) begin
            m[i*MCW +: MCW] = $urandom() & mask;
        end
        return m;
    endfunction

    //////////////////////////////////////////////////
    // handshake tasks
    //////////////////////////////////////////////////

    // returns 2 ns after the edge of the last transfer
    task automatic transfer(input vec_t v, input mat_t m,
                            input logic send_vec, input logic send_mat);
        logic vec_pending;
        logic mat_pending;
        logic vec_go;
        logic mat_go;
        int   cycles;
        vec_pending  = send_vec;
        mat_pending  = send_mat;
        cycles       = 0;
        vector       = v;
        matrix       = m;
        vector_valid = send_vec;
        matrix_valid = send_mat;
        while ((vec_pending || mat_pending) && cycles < 50) begin
            vec_go = vec_pending && vector_ready; // readies only move on an edge
            mat_go = mat_pending && matrix_ready;
            @(posedge clk);
            #2;
            cycles++;
            if (vec_go) begin
                vec_pending  = 1'b0;
                vector_valid = 1'b0;
            end
            if (mat_go) begin
                mat_pending  = 1'b0;
                matrix_valid = 1'b0;
            end
        end
        assert (!vec_pending && !mat_pending) else begin
            protocol_errors++;
            $display("%0t: operand handshake did not complete", $time);
            vector_valid = 1'b0;
            matrix_valid = 1'b0;
        end
    endtask

    task automatic wait_for_result();
        int cycles;
        cycles = 0;
        while (!result_valid && cycles < TILES + 10) begin
            assert (!vector_ready && !matrix_ready) else begin
                protocol_errors++;
                $display("%0t: an operand ready was high while a run was busy", $time);
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        assert (result_valid) else begin
            protocol_errors++;
            $display("%0t: result_valid never rose", $time);
        end
        assert (cycles == TILES + 2) else begin
            protocol_errors++;
            $display("%0t: result_valid rose after %0d cycles instead of %0d",
                     $time, cycles, TILES + 2);
        end
    endtask

    task automatic check_output(input res_t exp, input logic exp_err);
        assert (result === exp) else begin
            value_errors++;
            $display("[FAIL] %0t: result %h, expected %h", $time, result, exp);
        end
        assert (error === exp_err) else begin
            value_errors++;
            $display("[FAIL] %0t: error %b, expected %b", $time, error, exp_err);
        end
    endtask

    // holds result_ready low for delay cycles, then accepts
    task automatic take_result(input int delay, input res_t exp, input logic exp_err);
        res_t held;
        logic held_err;
        check_output(exp, exp_err);
        held     = result;
        held_err = error;
        repeat (delay) begin
            @(posedge clk);
            #2;
            assert (result_valid && result === held && error === held_err) else begin
                value_errors++;
                $display("[FAIL] %0t: result %h moved from %h under back-pressure",
                         $time, result, held);
            end
            assert (!vector_ready && !matrix_ready) else begin
                protocol_errors++;
                $display("%0t: an operand ready rose before the result was taken", $time);
            end
        end
        result_ready = 1'b1;
        @(posedge clk);
        #2;
        result_ready = 1'b0;
        assert (vector_ready && matrix_ready && !result_valid) else begin
            protocol_errors++;
            $display("%0t: block did not return to idle after acceptance", $time);
        end
    endtask

    // order 0 vector first, 1 matrix first, 2 both in one cycle
    task automatic run_once(input vec_t v, input mat_t m, input int order, input int delay);
        res_t exp;
        logic exp_err;
        expected_result(v, m, exp, exp_err);
        case (order)
            0: begin
                transfer(v, m, 1'b1, 1'b0);
                transfer(v, m, 1'b0, 1'b1);
            end
            1: begin
                transfer(v, m, 1'b0, 1'b1);
                transfer(v, m, 1'b1, 1'b0);
            end
            default: transfer(v, m, 1'b1, 1'b1);
        endcase
        wait_for_result();
        take_result(delay, exp, exp_err);
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic reset_and_idle();
        vec_t v;
        mat_t m;
        assert (vector_ready && matrix_ready && !result_valid && !error) else begin
            protocol_errors++;
            $display("%0t: wrong port levels after reset", $time);
        end
        for (int r = 0; r < MH; r++) begin
            v[r*VW +: VW] = VW'(r + 1);
        end
        for (int i = 0; i < MW*MH; i++) begin
            m[i*MCW +: MCW] = MCW'(i + 1); // whole cell index
        end
        run_once(v, m, 0, 0);
    endtask

    task automatic operand_order();
        run_once(random_vector(8'h1f), random_matrix(8'h1f), 1, 0);
        run_once(random_vector(8'h1f), random_matrix(8'h1f), 2, 0);
    endtask

    task automatic ready_while_busy();
        vec_t v_a;
        vec_t v_b;
        mat_t m;
        res_t exp;
        logic exp_err;
        v_a = random_vector(8'h1f);
        v_b = random_vector(8'h1f);
        m   = random_matrix(8'h1f);
        expected_result(v_a, m, exp, exp_err);
        transfer(v_a, m, 1'b1, 1'b1);
        vector       = v_b; // second vector waits on the port
        vector_valid = 1'b1;
        wait_for_result();
        take_result(0, exp, exp_err);
        run_once(v_b, random_matrix(8'h1f), 2, 0);
    endtask

    task automatic back_pressure();
        repeat (3) begin
            run_once(random_vector(8'h1f), random_matrix(8'h1f), 2, $urandom_range(10, 1));
        end
    endtask

    task automatic overflow_limits();
        vec_t v;
        mat_t m;
        run_once('1, '1, 2, 0); // full scale
        v = '0;
        m = '0;
        v[0*VW +: VW]           = 8'd255;
        v[1*VW +: VW]           = 8'd15;
        m[(0*MW + 2)*MCW +: MCW] = 8'd16;
        m[(1*MW + 2)*MCW +: MCW] = 8'd1;
        run_once(v, m, 2, 0);  // column 2 sums to 4095, shifts to 255
        m[(2*MW + 2)*MCW +: MCW] = 8'd1;
        v[2*VW +: VW]           = 8'd1;
        run_once(v, m, 2, 0);  // one more, shifts to 256
    endtask

    task automatic random_runs();
        logic [7:0] mask;
        repeat (20) begin
            mask = $urandom_range(1, 0) ? 8'hff : 8'h1f;
            repeat ($urandom_range(3, 0)) begin
                @(posedge clk);
                #2;
            end
            run_once(random_vector(mask), random_matrix(mask),
                     $urandom_range(2, 0), $urandom_range(10, 0));
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'he69));
        clk          = 1'b0;
        rst          = 1'b1;
        vector       = '0;
        vector_valid = 1'b0;
        matrix       = '0;
        matrix_valid = 1'b0;
        result_ready = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_and_idle();
        operand_order();
        ready_while_busy();
        back_pressure();
        overflow_limits();
        random_runs();
        $display("summary: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("run did not finish within %0d ns", WATCHDOG);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- src.f
hdl/mvm_pkg.sv
hdl/operand_buffer.sv
hdl/tile_sequencer.sv
hdl/vector_mac.sv
hdl/result_accumulator.sv
hdl/mvm.sv
bench/mvm_tb.sv
